/* e300_glue_top.f */
+incdir+.
e300_glue_pkg.sv
button_irq_gen.sv
sync_chain.sv
fe_ctrl_decode.sv
e300_glue_top.sv
tb_e300_glue_top.sv

/* tb_e300_glue_top.sv */
// Testbench for the E300 board glue top level
// Random stimulus from a fixed seed, checked every cycle against a cycle model
`timescale 1ns/1ns
`default_nettype none

`include "e300_glue_cfg.svh"

module tb_e300_glue_top;

  import e300_glue_pkg::*;

  logic                           bus_clk = 1'b0;
  logic                           bus_rst;
  logic                           onswitch_db;
  logic                           gps_pps;
  tcxo_status_t                   tcxo_raw;
  db_word_t                       db_gpio0;
  db_word_t                       db_gpio1;
  led_t                           leds0;
  led_t                           leds1;

  button_irq_t                    irq;
  logic                           pps_gpio;
  tcxo_status_t                   tcxo_status;
  fe_chan_t                       fe_ctrl0;
  fe_chan_t                       fe_ctrl1;
  logic [`E300_TX_BANDSEL_W-1:0]  tx_bandsel;
  led_t                           led_ch0;
  led_t                           led_ch1;

  // Stimulus control
  logic rst_req;
  logic hold_high;
  int   sw_left;
  int   n_press;
  int   n_rel;

  // Reference model state
  logic [1:0]                     hist_m;
  int                             press_cnt;
  int                             rel_cnt;
  logic                           pps_m [`E300_PPS_STAGES];
  tcxo_status_t                   stat_m [`E300_STATUS_STAGES];
  fe_chan_t                       fe0_m;
  fe_chan_t                       fe1_m;
  logic [`E300_TX_BANDSEL_W-1:0]  txb_m;
  led_t                           led0_m;
  led_t                           led1_m;

  e300_glue_top uut (
    .bus_clk     (bus_clk),
    .bus_rst     (bus_rst),
    .onswitch_db (onswitch_db),
    .gps_pps     (gps_pps),
    .tcxo_raw    (tcxo_raw),
    .db_gpio0    (db_gpio0),
    .db_gpio1    (db_gpio1),
    .leds0       (leds0),
    .leds1       (leds1),
    .irq         (irq),
    .pps_gpio    (pps_gpio),
    .tcxo_status (tcxo_status),
    .fe_ctrl0    (fe_ctrl0),
    .fe_ctrl1    (fe_ctrl1),
    .tx_bandsel  (tx_bandsel),
    .led_ch0     (led_ch0),
    .led_ch1     (led_ch1)
  );

  always #50 bus_clk = ~bus_clk;

  // ------------------------------
  // Checking
  // ------------------------------

  task automatic check(input string name, input logic [31:0] expected,
                       input logic [31:0] actual);
    if (actual !== expected) begin
      $display("** Error at %0t ns: %s expected 0x%0h, got 0x%0h",
               $time, name, expected, actual);
      $display("TB FAILED");
      $fatal(1, "Output mismatch");
    end
  endtask

  // Advance the model by one rising edge, using the inputs seen at that edge
  task automatic model_update();
    logic ev_press;
    logic ev_rel;
    // Active-low switch: high, high, then low is a press
    ev_press = !onswitch_db && (hist_m == 2'b11);
    ev_rel   = onswitch_db && (hist_m == 2'b00);
    if (bus_rst) begin
      hist_m    = 2'b00;
      press_cnt = 0;
      rel_cnt   = 0;
      for (int i = 0; i < `E300_PPS_STAGES; i++) pps_m[i] = 1'b0;
      for (int i = 0; i < `E300_STATUS_STAGES; i++) stat_m[i] = '0;
      fe0_m  = '0;
      fe1_m  = '0;
      txb_m  = '0;
      led0_m = '0;
      led1_m = '0;
    end else begin
      hist_m = {hist_m[0], onswitch_db};
      if (ev_press) begin
        press_cnt = `E300_STRETCH_LEN;
        n_press++;
      end else if (press_cnt > 0) begin
        press_cnt--;
      end
      if (ev_rel) begin
        rel_cnt = `E300_STRETCH_LEN;
        // Only releases from the random switch sequence count
        if (!hold_high) begin
          n_rel++;
        end
      end else if (rel_cnt > 0) begin
        rel_cnt--;
      end
      for (int i = `E300_PPS_STAGES - 1; i > 0; i--) pps_m[i] = pps_m[i-1];
      pps_m[0] = gps_pps;
      for (int i = `E300_STATUS_STAGES - 1; i > 0; i--) stat_m[i] = stat_m[i-1];
      stat_m[0] = tcxo_raw;
      // Front-end word is the GPIO word above the TX band select bits
      fe0_m  = db_gpio0[`E300_DB_WORD_W-1:`E300_TX_BANDSEL_W];
      fe1_m  = db_gpio1[`E300_DB_WORD_W-1:`E300_TX_BANDSEL_W];
      txb_m  = db_gpio0[`E300_TX_BANDSEL_W-1:0] | db_gpio1[`E300_TX_BANDSEL_W-1:0];
      led0_m = leds0;
      led1_m = leds1;
    end
  endtask

  task automatic compare_outputs();
    check("irq.press", press_cnt > 0, irq.press);
    check("irq.rel", rel_cnt > 0, irq.rel);
    check("pps_gpio", pps_m[`E300_PPS_STAGES-1], pps_gpio);
    check("tcxo_status", stat_m[`E300_STATUS_STAGES-1], tcxo_status);
    check("fe_ctrl0", fe0_m, fe_ctrl0);
    check("fe_ctrl1", fe1_m, fe_ctrl1);
    check("tx_bandsel", txb_m, tx_bandsel);
    check("led_ch0", led0_m, led_ch0);
    check("led_ch1", led1_m, led_ch1);
  endtask

  // ------------------------------
  // Stimulus
  // ------------------------------

  task automatic drive_inputs();
    logic [31:0] r;
    bus_rst = rst_req;
    if (hold_high) begin
      onswitch_db = 1'b1;
      sw_left     = 0;
    end else begin
      // Each switch level lasts 1 to 20 cycles
      if (sw_left == 0) begin
        onswitch_db = ~onswitch_db;
        sw_left     = $urandom_range(20, 1);
      end
      sw_left--;
    end
    if ($urandom_range(3, 0) == 0) gps_pps = ~gps_pps;
    r        = $urandom;
    tcxo_raw = r[3:0];
    leds0    = r[6:4];
    leds1    = r[9:7];
    r        = $urandom;
    db_gpio0 = r[15:0];
    db_gpio1 = r[31:16];
  endtask

  // One clock cycle: model and check just after the edge, then drive
  task automatic cycle();
    @(posedge bus_clk);
    #1;
    model_update();
    compare_outputs();
    #4;
    drive_inputs();
  endtask

  // Four rising edges see reset high
  task automatic apply_reset();
    rst_req = 1'b1;
    cycle();
    repeat (3) cycle();
    hold_high = 1'b1;
    rst_req   = 1'b0;
    cycle();
  endtask

  // A resting switch right after reset must raise the release interrupt
  task automatic wait_for_release();
    int n;
    n = 0;
    while (irq.rel !== 1'b1 && n < 20) begin
      cycle();
      n++;
    end
    if (irq.rel !== 1'b1) begin
      $display("Timed out waiting for the release interrupt after reset");
      $display("TB FAILED");
      $fatal(1, "Release interrupt never appeared");
    end
  endtask

  task automatic run_random(input int n);
    hold_high = 1'b0;
    repeat (n) cycle();
  endtask

  // ------------------------------
  // Main sequence
  // ------------------------------

  initial begin
    void'($urandom(32'h99717fe5));
    bus_rst     = 1'b1;
    rst_req     = 1'b1;
    hold_high   = 1'b0;
    sw_left     = 0;
    n_press     = 0;
    n_rel       = 0;
    onswitch_db = 1'b1;
    gps_pps     = 1'b0;
    tcxo_raw    = '0;
    db_gpio0    = '0;
    db_gpio1    = '0;
    leds0       = '0;
    leds1       = '0;
    hist_m      = 2'b00;
    press_cnt   = 0;
    rel_cnt     = 0;
    for (int i = 0; i < `E300_PPS_STAGES; i++) pps_m[i] = 1'b0;
    for (int i = 0; i < `E300_STATUS_STAGES; i++) stat_m[i] = '0;
    fe0_m  = '0;
    fe1_m  = '0;
    txb_m  = '0;
    led0_m = '0;
    led1_m = '0;

    // Power-on reset with random inputs, outputs must stay cleared
    repeat (3) cycle();
    hold_high = 1'b1;
    rst_req   = 1'b0;
    cycle();
    wait_for_release();
    run_random(400);

    // Reset in mid-run, then everything again
    apply_reset();
    wait_for_release();
    run_random(300);

    if (n_press == 0 || n_rel == 0) begin
      $display("The random switch sequence produced no press or no release event");
      $display("TB FAILED");
      $fatal(1, "Switch stimulus too weak");
    end else begin
      $display("TB PASSED");
      $finish;
    end
  end

endmodule

`default_nettype wire

/* e300_glue_top.sv */
// Board glue of the E300 bus_clk domain
// Button interrupts, PPS and TCXO status resync, front-end control decode
`timescale 1ns/1ns
`default_nettype none

`include "e300_glue_cfg.svh"

module e300_glue_top (
  input  wire                             bus_clk,
  input  wire                             bus_rst,

  // Switch, PPS and reference status
  input  wire                             onswitch_db,
  input  wire                             gps_pps,
  input  wire  e300_glue_pkg::tcxo_status_t tcxo_raw,

  // Radio core control words
  input  wire  e300_glue_pkg::db_word_t   db_gpio0,
  input  wire  e300_glue_pkg::db_word_t   db_gpio1,
  input  wire  e300_glue_pkg::led_t       leds0,
  input  wire  e300_glue_pkg::led_t       leds1,

  // To the processor
  output e300_glue_pkg::button_irq_t      irq,
  output logic                            pps_gpio,
  output e300_glue_pkg::tcxo_status_t     tcxo_status,

  // To the front-end pins
  output e300_glue_pkg::fe_chan_t         fe_ctrl0,
  output e300_glue_pkg::fe_chan_t         fe_ctrl1,
  output logic [`E300_TX_BANDSEL_W-1:0]   tx_bandsel,
  output e300_glue_pkg::led_t             led_ch0,
  output e300_glue_pkg::led_t             led_ch1
);

  import e300_glue_pkg::*;

  // ------------------------------
  // Button interrupts
  // ------------------------------

  button_irq_gen button_irq (
    .bus_clk     (bus_clk),
    .bus_rst     (bus_rst),
    .onswitch_db (onswitch_db),
    .irq         (irq)
  );

  // ------------------------------
  // Resync stages
  // ------------------------------

  // PPS onto a GPIO bit for the time daemon
  sync_chain #(
    .payload_t (logic),
    .STAGES    (`E300_PPS_STAGES)
  ) pps_sync (
    .bus_clk (bus_clk),
    .bus_rst (bus_rst),
    .din     (gps_pps),
    .dout    (pps_gpio)
  );

  // Reference loop status comes from the TCXO domain
  sync_chain #(
    .payload_t (tcxo_status_t),
    .STAGES    (`E300_STATUS_STAGES)
  ) status_sync (
    .bus_clk (bus_clk),
    .bus_rst (bus_rst),
    .din     (tcxo_raw),
    .dout    (tcxo_status)
  );

  // ------------------------------
  // Front-end controls
  // ------------------------------

  fe_ctrl_decode fe_decode (
    .bus_clk    (bus_clk),
    .bus_rst    (bus_rst),
    .db_gpio0   (db_gpio0),
    .db_gpio1   (db_gpio1),
    .leds0      (leds0),
    .leds1      (leds1),
    .fe_ctrl0   (fe_ctrl0),
    .fe_ctrl1   (fe_ctrl1),
    .tx_bandsel (tx_bandsel),
    .led_ch0    (led_ch0),
    .led_ch1    (led_ch1)
  );

endmodule

`default_nettype wire

/* fe_ctrl_decode.sv */
// Registered decode of both channels' daughterboard GPIO and LED words
// Drives antenna selects, TX enables, band selects and LEDs, all off in reset
`timescale 1ns/1ns
`default_nettype none

`include "e300_glue_cfg.svh"

module fe_ctrl_decode (
  input  wire                                bus_clk,
  input  wire                                bus_rst,
  input  wire  e300_glue_pkg::db_word_t      db_gpio0,
  input  wire  e300_glue_pkg::db_word_t      db_gpio1,
  input  wire  e300_glue_pkg::led_t          leds0,
  input  wire  e300_glue_pkg::led_t          leds1,
  output e300_glue_pkg::fe_chan_t            fe_ctrl0,
  output e300_glue_pkg::fe_chan_t            fe_ctrl1,
  output logic [`E300_TX_BANDSEL_W-1:0]      tx_bandsel,
  output e300_glue_pkg::led_t                led_ch0,
  output e300_glue_pkg::led_t                led_ch1
);

  import e300_glue_pkg::*;

  // Word layout must match the used part of the GPIO bus
  if ($bits(db_word_t) != `E300_DB_WORD_W) begin : g_width_check
    $error("db_word_t width does not match E300_DB_WORD_W");
  end

  // Field split of one channel, TX band select handled apart
  function automatic fe_chan_t to_fe_chan(input db_word_t w);
    fe_chan_t c;
    c.vcrx_v2     = w.vcrx_v2;
    c.vcrx_v1     = w.vcrx_v1;
    c.vctxrx_v2   = w.vctxrx_v2;
    c.vctxrx_v1   = w.vctxrx_v1;
    c.tx_enable_b = w.tx_enable_b;
    c.tx_enable_a = w.tx_enable_a;
    c.rxc_bandsel = w.rxc_bandsel;
    c.rxb_bandsel = w.rxb_bandsel;
    c.rx_bandsel  = w.rx_bandsel;
    return c;
  endfunction

  // ------------------------------
  // Output registers
  // ------------------------------

  always_ff @(posedge bus_clk) begin
    if (bus_rst) begin
      fe_ctrl0   <= '0;
      fe_ctrl1   <= '0;
      tx_bandsel <= '0;
      led_ch0    <= '0;
      led_ch1    <= '0;
    end else begin
      fe_ctrl0 <= to_fe_chan(db_gpio0);
      fe_ctrl1 <= to_fe_chan(db_gpio1);
      // Both channels are always tuned to the same band, so either
      // channel alone can set the shared select
      tx_bandsel <= db_gpio0.tx_bandsel | db_gpio1.tx_bandsel;
      led_ch0    <= leds0;
      led_ch1    <= leds1;
    end
  end

  // ------------------------------
  // Checks
  // ------------------------------

  // No transmitter may be enabled as reset lets go
  a_tx_off_after_reset: assert property (
    @(posedge bus_clk)
      bus_rst ##1 !bus_rst |->
        !fe_ctrl0.tx_enable_a && !fe_ctrl0.tx_enable_b &&
        !fe_ctrl1.tx_enable_a && !fe_ctrl1.tx_enable_b
  ) else $error("TX enable active on reset release");

endmodule

`default_nettype wire

/* sync_chain.sv */
// Multi-stage register chain that brings asynchronous levels into bus_clk
// Set payload_t to the carried type and STAGES to the depth
`timescale 1ns/1ns
`default_nettype none

module sync_chain #(
  parameter type payload_t = logic,
  parameter int  STAGES    = 2
) (
  input  wire      bus_clk,
  input  wire      bus_rst,
  input  payload_t din,
  output payload_t dout
);

  // stage_q[0] samples the asynchronous input
  payload_t stage_q [STAGES];

  always_ff @(posedge bus_clk) begin
    if (bus_rst) begin
      for (int i = 0; i < STAGES; i++) begin
        stage_q[i] <= '0;
      end
    end else begin
      stage_q[0] <= din;
      for (int i = 1; i < STAGES; i++) begin
        stage_q[i] <= stage_q[i-1];
      end
    end
  end

  assign dout = stage_q[STAGES-1];

  // ------------------------------
  // Checks
  // ------------------------------

  // Once the chain has refilled after reset, the output is the
  // input delayed by exactly STAGES cycles
  a_fixed_latency: assert property (
    @(posedge bus_clk)
      (!bus_rst) [*STAGES] |=> (dout == $past(din, STAGES))
  ) else $error("sync_chain output does not match delayed input");

endmodule

`default_nettype wire

/* button_irq_gen.sv */
// On-switch edge detection with stretched press and release interrupts
// Takes the debounced, active-low switch level already in bus_clk
`timescale 1ns/1ns
`default_nettype none

`include "e300_glue_cfg.svh"

module button_irq_gen (
  input  wire                        bus_clk,
  input  wire                        bus_rst,
  input  wire                        onswitch_db,
  output e300_glue_pkg::button_irq_t irq
);

  import e300_glue_pkg::*;

  // Two previous switch samples, [0] is the most recent
  logic [1:0] hist_q;

  // Single-cycle events before stretching
  button_irq_t evt;

  logic [`E300_STRETCH_LEN-1:0] press_sr;
  logic [`E300_STRETCH_LEN-1:0] rel_sr;

  // ------------------------------
  // Edge detection
  // ------------------------------

  // Cleared history reads as pressed, so a resting switch
  // gives one release event right after reset
  always_ff @(posedge bus_clk) begin
    if (bus_rst) begin
      hist_q <= 2'b00;
    end else begin
      hist_q <= {hist_q[0], onswitch_db};
    end
  end

  // Switch is active low, press is high-high-low
  always_comb begin
    evt.press = ~onswitch_db & hist_q[0] & hist_q[1];
    evt.rel   = onswitch_db & ~hist_q[0] & ~hist_q[1];
  end

  // ------------------------------
  // Pulse stretching
  // ------------------------------

  // Each event runs down its own shift register, a new
  // event restarts the window
  always_ff @(posedge bus_clk) begin
    if (bus_rst) begin
      press_sr <= '0;
      rel_sr   <= '0;
    end else begin
      press_sr <= {press_sr[`E300_STRETCH_LEN-2:0], evt.press};
      rel_sr   <= {rel_sr[`E300_STRETCH_LEN-2:0], evt.rel};
    end
  end

  always_comb begin
    irq.press = |press_sr;
    irq.rel   = |rel_sr;
  end

  // ------------------------------
  // Checks
  // ------------------------------

  // Every event holds its interrupt for the whole stretch window
  a_press_stretch: assert property (
    @(posedge bus_clk) disable iff (bus_rst)
      evt.press |=> irq.press [*`E300_STRETCH_LEN]
  ) else $error("press interrupt shorter than the stretch window");

  a_rel_stretch: assert property (
    @(posedge bus_clk) disable iff (bus_rst)
      evt.rel |=> irq.rel [*`E300_STRETCH_LEN]
  ) else $error("release interrupt shorter than the stretch window");

endmodule

`default_nettype wire

/* e300_glue_pkg.sv */
// Packed types shared by the board glue RTL and its testbench
// Field order follows the daughterboard GPIO and LED bit layout, MSB first
`default_nettype none

`include "e300_glue_cfg.svh"

package e300_glue_pkg;

  // ------------------------------
  // Button interrupts
  // ------------------------------

  // Stretched press and release interrupt lines
  typedef struct packed {
    logic press;
    logic rel;
  } button_irq_t;

  // ------------------------------
  // Reference clock status
  // ------------------------------

  typedef struct packed {
    logic plllck;
    logic is_10meg;
    logic is_pps;
    logic reflck;
  } tcxo_status_t;

  // ------------------------------
  // Front-end control words
  // ------------------------------

  // One channel's daughterboard GPIO word
  typedef struct packed {
    logic                                vcrx_v2;
    logic                                vcrx_v1;
    logic                                vctxrx_v2;
    logic                                vctxrx_v1;
    logic                                tx_enable_b;
    logic                                tx_enable_a;
    logic [`E300_RX_SUB_BANDSEL_W-1:0]   rxc_bandsel;
    logic [`E300_RX_SUB_BANDSEL_W-1:0]   rxb_bandsel;
    logic [`E300_RX_BANDSEL_W-1:0]       rx_bandsel;
    logic [`E300_TX_BANDSEL_W-1:0]       tx_bandsel;
  } db_word_t;

  // Per-channel pins, TX band select goes out shared
  typedef struct packed {
    logic                                vcrx_v2;
    logic                                vcrx_v1;
    logic                                vctxrx_v2;
    logic                                vctxrx_v1;
    logic                                tx_enable_b;
    logic                                tx_enable_a;
    logic [`E300_RX_SUB_BANDSEL_W-1:0]   rxc_bandsel;
    logic [`E300_RX_SUB_BANDSEL_W-1:0]   rxb_bandsel;
    logic [`E300_RX_BANDSEL_W-1:0]       rx_bandsel;
  } fe_chan_t;

  typedef struct packed {
    logic rx_rx;
    logic txrx_tx;
    logic txrx_rx;
  } led_t;

endpackage

`default_nettype wire

/* e300_glue_cfg.svh */
// Build-time constants for the E300 board glue logic
// Include in any file that needs stage counts, pulse lengths or word widths
`ifndef E300_GLUE_CFG_SVH
`define E300_GLUE_CFG_SVH

// ------------------------------
// Interrupt stretching
// ------------------------------

// Button interrupt pulse length in bus_clk cycles
`define E300_STRETCH_LEN 8

// ------------------------------
// Resync depths
// ------------------------------

`define E300_PPS_STAGES 3
`define E300_STATUS_STAGES 2

// ------------------------------
// Daughterboard word layout
// ------------------------------

// Used part of each channel's GPIO word
`define E300_DB_WORD_W 16
`define E300_TX_BANDSEL_W 3
`define E300_RX_BANDSEL_W 3
`define E300_RX_SUB_BANDSEL_W 2

`endif
